// File: source/tia_macros.svh
// --------------------------------------------------------------------------
// Register map and beam timing constants for the video core
// Write and read addresses, line timing, playfield and player spans
// --------------------------------------------------------------------------
`ifndef TIA_MACROS_SVH
`define TIA_MACROS_SVH

// Line timing in color clocks
`define TIA_LINE_LENGTH  8'd228
`define TIA_HBLANK_END   8'd68
`define TIA_HSYNC_START  8'd20
`define TIA_HSYNC_END    8'd36
`define TIA_WSYNC_GUARD  8'd2
`define TIA_BLANK_PIXEL  8'd227

// Object geometry
`define TIA_PF_HALF      6'd20
`define TIA_OBJ_SPAN     9'd72

// Write addresses
`define TIA_WSYNC   6'h02
`define TIA_NUSIZ0  6'h04
`define TIA_NUSIZ1  6'h05
`define TIA_COLUP0  6'h06
`define TIA_COLUP1  6'h07
`define TIA_COLUPF  6'h08
`define TIA_COLUBK  6'h09
`define TIA_CTRLPF  6'h0A
`define TIA_REFP0   6'h0B
`define TIA_REFP1   6'h0C
`define TIA_PF0     6'h0D
`define TIA_PF1     6'h0E
`define TIA_PF2     6'h0F
`define TIA_RESP0   6'h10
`define TIA_RESP1   6'h11
`define TIA_GRP0    6'h1B
`define TIA_GRP1    6'h1C
`define TIA_CXCLR   6'h2C

// Read addresses
`define TIA_CXP0FB  6'h02
`define TIA_CXP1FB  6'h03
`define TIA_CXPPMM  6'h07

`endif

// File: source/tiaPkg.sv
// --------------------------------------------------------------------------
// Shared types of the video core
// Bus, beam, color and object widths
// --------------------------------------------------------------------------
package tiaPkg;

   // Bus side
   typedef logic [5:0] tiaAddrT;
   typedef logic [7:0] busDataT;

   // Beam position
   typedef logic [7:0] hCountT;
   typedef logic [7:0] pixelNumT;

   // Indexed color value
   typedef logic [7:0] colorT;

   // Playfield bits in display order, left half only
   typedef logic [19:0] pfGraphicT;

   // Player objects
   typedef logic [7:0] playerGraphicT;
   typedef logic [2:0] playerSizeT;

   // bit0 player0/playfield, bit1 player1/playfield, bit2 player0/player1
   typedef logic [2:0] collisionT;

endpackage

// File: source/tiaBusDecode.sv
// --------------------------------------------------------------------------
// Bus decode
// One registered strobe per write address, registered write data
// and registered read data
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "tia_macros.svh"

module tiaBusDecode import tiaPkg::*; (
   input  logic    MASTERCLK,
   input  logic    collisionLatchReset,
   input  logic    CS,
   input  logic    R_W_n,
   input  tiaAddrT A,
   input  busDataT Din,
   input  busDataT readValue,
   output logic    wsyncStrobe,
   output logic    nusiz0Strobe,
   output logic    nusiz1Strobe,
   output logic    colup0Strobe,
   output logic    colup1Strobe,
   output logic    colupfStrobe,
   output logic    colubkStrobe,
   output logic    ctrlpfStrobe,
   output logic    refp0Strobe,
   output logic    refp1Strobe,
   output logic    pf0Strobe,
   output logic    pf1Strobe,
   output logic    pf2Strobe,
   output logic    resp0Strobe,
   output logic    resp1Strobe,
   output logic    grp0Strobe,
   output logic    grp1Strobe,
   output logic    cxclrStrobe,
   output busDataT wrData,
   output tiaAddrT readAddr,
   output busDataT Dout
);
   logic writeCycle;
   logic readCycle;

   assign writeCycle = CS && !R_W_n;
   assign readCycle  = CS && R_W_n;

   // Collision mux looks up the read address in the same cycle
   assign readAddr = A;

   always_ff @(posedge MASTERCLK, posedge collisionLatchReset) begin
      if (collisionLatchReset) begin
         wsyncStrobe  <= 1'b0;
         nusiz0Strobe <= 1'b0;
         nusiz1Strobe <= 1'b0;
         colup0Strobe <= 1'b0;
         colup1Strobe <= 1'b0;
         colupfStrobe <= 1'b0;
         colubkStrobe <= 1'b0;
         ctrlpfStrobe <= 1'b0;
         refp0Strobe  <= 1'b0;
         refp1Strobe  <= 1'b0;
         pf0Strobe    <= 1'b0;
         pf1Strobe    <= 1'b0;
         pf2Strobe    <= 1'b0;
         resp0Strobe  <= 1'b0;
         resp1Strobe  <= 1'b0;
         grp0Strobe   <= 1'b0;
         grp1Strobe   <= 1'b0;
         cxclrStrobe  <= 1'b0;
         wrData       <= '0;
         Dout         <= '0;
      end else begin
         wsyncStrobe  <= writeCycle && (A == `TIA_WSYNC);
         nusiz0Strobe <= writeCycle && (A == `TIA_NUSIZ0);
         nusiz1Strobe <= writeCycle && (A == `TIA_NUSIZ1);
         colup0Strobe <= writeCycle && (A == `TIA_COLUP0);
         colup1Strobe <= writeCycle && (A == `TIA_COLUP1);
         colupfStrobe <= writeCycle && (A == `TIA_COLUPF);
         colubkStrobe <= writeCycle && (A == `TIA_COLUBK);
         ctrlpfStrobe <= writeCycle && (A == `TIA_CTRLPF);
         refp0Strobe  <= writeCycle && (A == `TIA_REFP0);
         refp1Strobe  <= writeCycle && (A == `TIA_REFP1);
         pf0Strobe    <= writeCycle && (A == `TIA_PF0);
         pf1Strobe    <= writeCycle && (A == `TIA_PF1);
         pf2Strobe    <= writeCycle && (A == `TIA_PF2);
         resp0Strobe  <= writeCycle && (A == `TIA_RESP0);
         resp1Strobe  <= writeCycle && (A == `TIA_RESP1);
         grp0Strobe   <= writeCycle && (A == `TIA_GRP0);
         grp1Strobe   <= writeCycle && (A == `TIA_GRP1);
         cxclrStrobe  <= writeCycle && (A == `TIA_CXCLR);
         // Data travels alongside its strobe
         wrData       <= Din;
         // Unmapped addresses already come back as zero
         Dout         <= readCycle ? readValue : '0;
      end
   end

endmodule

// File: source/tiaBeamCounter.sv
// --------------------------------------------------------------------------
// Horizontal beam counter
// Sync and blank decode, visible pixel index, WSYNC hold on RDY
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "tia_macros.svh"

module tiaBeamCounter import tiaPkg::*; (
   input  logic     MASTERCLK,
   input  logic     collisionLatchReset,
   input  logic     wsyncStrobe,
   output logic     HSYNC,
   output logic     HBLANK,
   output pixelNumT pixelNum,
   output logic     RDY
);
   hCountT hCount;
   logic   lineEnd;
   logic   wsyncHold;

   assign lineEnd = (hCount == (`TIA_LINE_LENGTH - 8'd1));

   always_ff @(posedge MASTERCLK, posedge collisionLatchReset) begin
      if (collisionLatchReset) begin
         hCount    <= '0;
         wsyncHold <= 1'b0;
      end else begin
         hCount <= lineEnd ? '0 : hCount + 8'd1;
         // Hold lasts until the line wraps
         if (lineEnd) begin
            wsyncHold <= 1'b0;
         end else if (wsyncStrobe && !wsyncHold) begin
            wsyncHold <= 1'b1;
         end
      end
   end

   assign HSYNC  = (hCount >= `TIA_HSYNC_START) && (hCount < `TIA_HSYNC_END);
   assign HBLANK = (hCount < `TIA_HBLANK_END);

   // Blank pixels park at a fixed index
   assign pixelNum = HBLANK ? `TIA_BLANK_PIXEL : hCount - `TIA_HBLANK_END;

   // Stall only past the first few counts of the line
   assign RDY = !(wsyncHold && (hCount > `TIA_WSYNC_GUARD));

endmodule

// File: source/tiaObjectRegisters.sv
// --------------------------------------------------------------------------
// Software-written object state
// Playfield, player, color and control registers
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module tiaObjectRegisters import tiaPkg::*; (
   input  logic          MASTERCLK,
   input  logic          collisionLatchReset,
   input  logic          nusiz0Strobe,
   input  logic          nusiz1Strobe,
   input  logic          colup0Strobe,
   input  logic          colup1Strobe,
   input  logic          colupfStrobe,
   input  logic          colubkStrobe,
   input  logic          ctrlpfStrobe,
   input  logic          refp0Strobe,
   input  logic          refp1Strobe,
   input  logic          pf0Strobe,
   input  logic          pf1Strobe,
   input  logic          pf2Strobe,
   input  logic          resp0Strobe,
   input  logic          resp1Strobe,
   input  logic          grp0Strobe,
   input  logic          grp1Strobe,
   input  busDataT       wrData,
   input  pixelNumT      pixelNum,
   output pfGraphicT     pfGraphic,
   output logic          pfReflect,
   output logic          pfScoreMode,
   output logic          pfPriority,
   output colorT         pfColor,
   output colorT         bgColor,
   output colorT         player0Color,
   output colorT         player1Color,
   output pixelNumT      player0Pos,
   output pixelNumT      player1Pos,
   output playerSizeT    player0Size,
   output playerSizeT    player1Size,
   output playerGraphicT player0Graphic,
   output playerGraphicT player1Graphic,
   output logic          player0Reflect,
   output logic          player1Reflect
);
   playerGraphicT grp0Data;
   playerGraphicT grp1Data;

   always_ff @(posedge MASTERCLK, posedge collisionLatchReset) begin
      if (collisionLatchReset) begin
         pfGraphic      <= '0;
         pfReflect      <= 1'b0;
         pfScoreMode    <= 1'b0;
         pfPriority     <= 1'b0;
         pfColor        <= '0;
         bgColor        <= '0;
         player0Color   <= '0;
         player1Color   <= '0;
         player0Pos     <= '0;
         player1Pos     <= '0;
         player0Size    <= '0;
         player1Size    <= '0;
         grp0Data       <= '0;
         grp1Data       <= '0;
         player0Reflect <= 1'b0;
         player1Reflect <= 1'b0;
      end else begin
         if (nusiz0Strobe) player0Size <= wrData[2:0];
         if (nusiz1Strobe) player1Size <= wrData[2:0];
         if (colup0Strobe) player0Color <= wrData;
         if (colup1Strobe) player1Color <= wrData;
         if (colupfStrobe) pfColor <= wrData;
         if (colubkStrobe) bgColor <= wrData;
         if (ctrlpfStrobe) begin
            pfReflect   <= wrData[0];
            pfScoreMode <= wrData[1];
            pfPriority  <= wrData[2];
         end
         if (refp0Strobe) player0Reflect <= wrData[3];
         if (refp1Strobe) player1Reflect <= wrData[3];
         // PF0 uses its high nibble, PF1 is stored MSB first
         if (pf0Strobe) pfGraphic[3:0] <= wrData[7:4];
         if (pf1Strobe) pfGraphic[11:4] <= {<<{wrData}};
         if (pf2Strobe) pfGraphic[19:12] <= wrData;
         if (resp0Strobe) player0Pos <= pixelNum;
         if (resp1Strobe) player1Pos <= pixelNum;
         if (grp0Strobe) grp0Data <= wrData;
         if (grp1Strobe) grp1Data <= wrData;
      end
   end

   // Index 0 is the first pixel drawn, D7 unless reflected
   assign player0Graphic = player0Reflect ? grp0Data : {<<{grp0Data}};
   assign player1Graphic = player1Reflect ? grp1Data : {<<{grp1Data}};

endmodule

// File: source/tiaPlayerPixel.sv
// --------------------------------------------------------------------------
// Player pixel test
// Copy pattern, stretch and window check for one player
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "tia_macros.svh"

module tiaPlayerPixel import tiaPkg::*; (
   input  pixelNumT      pixelNum,
   input  pixelNumT      objPos,
   input  playerSizeT    objSize,
   input  playerGraphicT objGraphic,
   output logic          pixelOn
);
   logic [7:0] objIndex;
   logic [8:0] slotBit;
   logic [8:0] copyMask;
   logic [2:0] bitSel;
   logic       copyOn;
   logic       inWindow;

   // Drawing starts one pixel after the position
   assign objIndex = pixelNum - objPos - 8'd1;

   // Which 8-pixel slot of the window this pixel falls in
   assign slotBit = 9'd1 << objIndex[7:3];

   always_comb begin
      case (objSize)
         3'd0: copyMask = 9'b0_0000_0001;
         3'd1: copyMask = 9'b0_0000_0101;
         3'd2: copyMask = 9'b0_0001_0001;
         3'd3: copyMask = 9'b0_0001_0101;
         3'd4: copyMask = 9'b1_0000_0001;
         3'd5: copyMask = 9'b0_0000_0011;
         3'd6: copyMask = 9'b1_0001_0001;
         default: copyMask = 9'b0_0000_1111;
      endcase
   end

   // Double and quad widths repeat each bit
   always_comb begin
      case (objSize)
         3'd5: bitSel = objIndex[3:1];
         3'd7: bitSel = objIndex[4:2];
         default: bitSel = objIndex[2:0];
      endcase
   end

   assign copyOn   = |(copyMask & slotBit);
   assign inWindow = (pixelNum > objPos) &&
                     ({1'b0, pixelNum} <= ({1'b0, objPos} + `TIA_OBJ_SPAN));
   assign pixelOn  = inWindow && copyOn && objGraphic[bitSel];

endmodule

// File: source/tiaPixelPriority.sv
// --------------------------------------------------------------------------
// Playfield pixel test and final color selection
// Repeat or reflect of the right half, score colors, object priority
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "tia_macros.svh"

module tiaPixelPriority import tiaPkg::*; (
   input  pixelNumT  pixelNum,
   input  logic      HBLANK,
   input  pfGraphicT pfGraphic,
   input  logic      pfReflect,
   input  logic      pfScoreMode,
   input  logic      pfPriority,
   input  colorT     pfColor,
   input  colorT     bgColor,
   input  colorT     player0Color,
   input  colorT     player1Color,
   input  logic      player0On,
   input  logic      player1On,
   output logic      pfOn,
   output colorT     COLOROUT
);
   logic [5:0] pfIndex;
   logic [5:0] rightIndex;
   logic [4:0] pfSel;
   logic       leftHalf;
   colorT      pfShownColor;
   colorT      pixelColor;

   // Each playfield bit covers four pixels
   assign pfIndex  = pixelNum[7:2];
   assign leftHalf = (pfIndex < `TIA_PF_HALF);

   assign rightIndex = pfReflect ? (6'd2 * `TIA_PF_HALF - 6'd1) - pfIndex
                                 : pfIndex - `TIA_PF_HALF;
   assign pfSel = leftHalf ? pfIndex[4:0] : rightIndex[4:0];

   // Blank index lands outside both halves
   assign pfOn = !HBLANK && pfGraphic[pfSel];

   // Score mode paints each half in its player's color
   always_comb begin
      if (!pfScoreMode) begin
         pfShownColor = pfColor;
      end else if (leftHalf) begin
         pfShownColor = player0Color;
      end else begin
         pfShownColor = player1Color;
      end
   end

   always_comb begin
      if (pfPriority && pfOn) begin
         pixelColor = pfShownColor;
      end else if (player0On) begin
         pixelColor = player0Color;
      end else if (player1On) begin
         pixelColor = player1Color;
      end else if (pfOn) begin
         pixelColor = pfShownColor;
      end else begin
         pixelColor = bgColor;
      end
   end

   assign COLOROUT = HBLANK ? '0 : pixelColor;

endmodule

// File: source/tiaCollisionRead.sv
// --------------------------------------------------------------------------
// Collision latches and bus read multiplexer
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "tia_macros.svh"

module tiaCollisionRead import tiaPkg::*; (
   input  logic    MASTERCLK,
   input  logic    collisionLatchReset,
   input  logic    cxclrStrobe,
   input  logic    HBLANK,
   input  logic    player0On,
   input  logic    player1On,
   input  logic    pfOn,
   input  tiaAddrT readAddr,
   output busDataT readValue
);
   collisionT collisionLatch;
   collisionT collisionNow;

   assign collisionNow = {player0On && player1On, player1On && pfOn, player0On && pfOn};

   always_ff @(posedge MASTERCLK, posedge collisionLatchReset) begin
      if (collisionLatchReset) begin
         collisionLatch <= '0;
      end else if (cxclrStrobe) begin
         collisionLatch <= '0;
      end else if (!HBLANK) begin
         // Sticky until cleared by software
         collisionLatch <= collisionLatch | collisionNow;
      end
   end

   // Flag sits in bit 7, the rest reads as zero
   always_comb begin
      case (readAddr)
         `TIA_CXP0FB: readValue = {collisionLatch[0], 7'b0};
         `TIA_CXP1FB: readValue = {collisionLatch[1], 7'b0};
         `TIA_CXPPMM: readValue = {collisionLatch[2], 7'b0};
         default: readValue = '0;
      endcase
   end

endmodule

// File: source/tiaTop.sv
// --------------------------------------------------------------------------
// Video core top level
// Bus decode, beam counter, object state, pixel tests and collisions
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module tiaTop import tiaPkg::*; (
   input  logic    MASTERCLK,
   input  logic    collisionLatchReset,
   input  logic    CS,
   input  logic    R_W_n,
   input  tiaAddrT A,
   input  busDataT Din,
   output busDataT Dout,
   output logic    RDY,
   output logic    HSYNC,
   output logic    HBLANK,
   output colorT   COLOROUT
);
   logic wsyncStrobe, nusiz0Strobe, nusiz1Strobe, colup0Strobe, colup1Strobe;
   logic colupfStrobe, colubkStrobe, ctrlpfStrobe, refp0Strobe, refp1Strobe;
   logic pf0Strobe, pf1Strobe, pf2Strobe, resp0Strobe, resp1Strobe;
   logic grp0Strobe, grp1Strobe, cxclrStrobe;
   busDataT       wrData, readValue;
   tiaAddrT       readAddr;
   pixelNumT      pixelNum, player0Pos, player1Pos;
   pfGraphicT     pfGraphic;
   logic          pfReflect, pfScoreMode, pfPriority;
   colorT         pfColor, bgColor, player0Color, player1Color;
   playerSizeT    player0Size, player1Size;
   playerGraphicT player0Graphic, player1Graphic;
   logic          player0On, player1On, pfOn;

   tiaBusDecode busDecode (.*);

   tiaBeamCounter beamCounter (.*);

   // Reflect flags are folded into the player graphics
   tiaObjectRegisters objectRegisters (
      .*,
      .player0Reflect(),
      .player1Reflect()
   );

   tiaPlayerPixel player0Test (
      .pixelNum  (pixelNum),
      .objPos    (player0Pos),
      .objSize   (player0Size),
      .objGraphic(player0Graphic),
      .pixelOn   (player0On)
   );

   tiaPlayerPixel player1Test (
      .pixelNum  (pixelNum),
      .objPos    (player1Pos),
      .objSize   (player1Size),
      .objGraphic(player1Graphic),
      .pixelOn   (player1On)
   );

   tiaPixelPriority pixelPriority (.*);

   tiaCollisionRead collisionRead (.*);

endmodule

// File: test/tiaTop_properties.sv
// --------------------------------------------------------------------------
// Concurrent assertions on the video core outputs
// Sync inside blank, black blank, sync width, RDY after the line wrap
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module tiaTop_properties import tiaPkg::*; (
   input logic  MASTERCLK,
   input logic  collisionLatchReset,
   input logic  HSYNC,
   input logic  HBLANK,
   input logic  RDY,
   input logic  wsyncStrobe,
   input colorT COLOROUT
);

   syncInBlank: assert property (@(posedge MASTERCLK) disable iff (collisionLatchReset)
      HSYNC |-> HBLANK) else $error("HSYNC outside HBLANK");

   blankIsBlack: assert property (@(posedge MASTERCLK) disable iff (collisionLatchReset)
      HBLANK |-> (COLOROUT == '0)) else $error("COLOROUT not zero during HBLANK");

   // Sync pulse is 16 counts wide
   syncWidth: assert property (@(posedge MASTERCLK) disable iff (collisionLatchReset)
      $rose(HSYNC) |-> ##15 HSYNC ##1 !HSYNC) else $error("HSYNC width wrong");

   // WSYNC hold is gone by count 0, first visible on RDY at count 3
   // A fresh WSYNC in counts 0 to 2 may set it again
   readyAtLineStart: assert property (@(posedge MASTERCLK) disable iff (collisionLatchReset)
      $rose(HBLANK) |-> ##3 (RDY || $past(wsyncStrobe, 1) || $past(wsyncStrobe, 2) ||
                             $past(wsyncStrobe, 3)))
      else $error("RDY low after the line wrap");

endmodule

bind tiaTop tiaTop_properties tiaTopProps (.*);

// File: test/tiaTop_tb.sv
// --------------------------------------------------------------------------
// Testbench for the video core
// Clock, reset, row table, reference model, checks and watchdog
// --------------------------------------------------------------------------
`timescale 1ns/1ns
`include "tia_macros.svh"

module tiaTop_tb import tiaPkg::*; ();
   localparam int NUM_ROWS = 23;
   // Each row spans about five lines, plus the timing and WSYNC tests
   localparam int TIMEOUT_NS = (NUM_ROWS * 6 + 10) * 228 * 100;

   typedef struct packed {
      logic [7:0] pf0, pf1, pf2, ctrl;
      logic [2:0] nus0;
      logic       ref0;
      logic [7:0] g0, pos0, g1, pos1, x;
   } rowT;

   logic MASTERCLK, collisionLatchReset, CS, R_W_n, RDY, HSYNC, HBLANK;
   tiaAddrT A;
   busDataT Din, Dout;
   colorT COLOROUT;
   rowT rows[$];
   rowT cur;
   colorT colP0, colP1, colPF, colBK;
   int errors = 0;
   int checks = 0;

   tiaTop i_tiaTop (.*);

   initial begin
      MASTERCLK = 1'b0;
      forever #50 MASTERCLK = ~MASTERCLK;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: the tests did not finish in the expected time");
      $display("TESTBENCH FAILED");
      $finish;
   end

   task automatic checkValue(string name, logic [7:0] expected, logic [7:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      end
   endtask

   task automatic busWrite(tiaAddrT addr, busDataT data);
      @(posedge MASTERCLK);
      CS <= 1'b1;
      R_W_n <= 1'b0;
      A <= addr;
      Din <= data;
      @(posedge MASTERCLK);
      CS <= 1'b0;
      R_W_n <= 1'b1;
   endtask

   task automatic busRead(tiaAddrT addr, output busDataT data);
      @(posedge MASTERCLK);
      CS <= 1'b1;
      R_W_n <= 1'b1;
      A <= addr;
      @(posedge MASTERCLK);
      CS <= 1'b0;
      @(negedge MASTERCLK);
      data = Dout;
   endtask

   task automatic addRow(logic [7:0] pf0, pf1, pf2, ctrl, logic [2:0] nus0, logic ref0,
                         logic [7:0] g0, pos0, g1, pos1, x);
      rows.push_back({pf0, pf1, pf2, ctrl, nus0, ref0, g0, pos0, g1, pos1, x});
   endtask

   // Playfield bit order: PF0 D4..D7, PF1 D7..D0, PF2 D0..D7
   function automatic logic pfModel(int x);
      int idx;
      idx = x / 4;
      if (idx >= 20) idx = cur.ctrl[0] ? 39 - idx : idx - 20;
      if (idx < 4) return cur.pf0[4 + idx];
      if (idx < 12) return cur.pf1[11 - idx];
      return cur.pf2[idx - 12];
   endfunction

   function automatic logic copyAt(logic [2:0] size, int c);
      case (size)
         3'd1: return c == 0 || c == 1;
         3'd2: return c == 0 || c == 2;
         3'd3: return c <= 2;
         3'd4: return c == 0 || c == 4;
         3'd6: return c == 0 || c == 2 || c == 4;
         default: return c == 0;
      endcase
   endfunction

   function automatic logic playerModel(int x, int pos, logic [2:0] size,
                                        logic [7:0] g, logic refl);
      int idx;
      int w;
      int b;
      logic on;
      on = 1'b0;
      idx = x - pos - 1;
      w = (size == 3'd5) ? 16 : (size == 3'd7) ? 32 : 8;
      if (idx < 0 || idx >= 72) return 1'b0;
      for (int c = 0; c < 5; c++) begin
         if (copyAt(size, c) && idx >= c * 16 && idx < c * 16 + w) begin
            b = (idx - c * 16) / (w / 8);
            on = refl ? g[b] : g[7 - b];
         end
      end
      return on;
   endfunction

   function automatic colorT colorModel(int x);
      logic p0;
      logic p1;
      logic pf;
      colorT pfc;
      p0 = playerModel(x, cur.pos0, cur.nus0, cur.g0, cur.ref0);
      p1 = playerModel(x, cur.pos1, 3'd0, cur.g1, 1'b0);
      pf = pfModel(x);
      pfc = !cur.ctrl[1] ? colPF : (x < 80 ? colP0 : colP1);
      if (cur.ctrl[2] && pf) return pfc;
      if (p0) return colP0;
      if (p1) return colP1;
      if (pf) return pfc;
      return colBK;
   endfunction

   // Position p needs the strobe at pixel p, so the drive starts at count p + 67
   task automatic placePlayer(tiaAddrT addr, int pos);
      @(negedge HBLANK);
      repeat (pos - 2) @(posedge MASTERCLK);
      busWrite(addr, 8'h00);
   endtask

   task automatic runRow(int n);
      busDataT rd;
      logic [2:0] cx;
      cur = rows[n];
      @(posedge HBLANK);
      busWrite(`TIA_COLUP0, colP0);
      busWrite(`TIA_COLUP1, colP1);
      busWrite(`TIA_COLUPF, colPF);
      busWrite(`TIA_COLUBK, colBK);
      busWrite(`TIA_CTRLPF, cur.ctrl);
      busWrite(`TIA_REFP0, cur.ref0 ? 8'h08 : 8'h00);
      busWrite(`TIA_REFP1, 8'h00);
      busWrite(`TIA_PF0, cur.pf0);
      busWrite(`TIA_PF1, cur.pf1);
      busWrite(`TIA_PF2, cur.pf2);
      busWrite(`TIA_NUSIZ0, {5'b0, cur.nus0});
      busWrite(`TIA_NUSIZ1, 8'h00);
      busWrite(`TIA_GRP0, cur.g0);
      busWrite(`TIA_GRP1, cur.g1);
      placePlayer(`TIA_RESP0, cur.pos0);
      placePlayer(`TIA_RESP1, cur.pos1);
      // One clean line of collisions after the clear
      @(posedge HBLANK);
      busWrite(`TIA_CXCLR, 8'h00);
      @(negedge HBLANK);
      repeat (cur.x) @(posedge MASTERCLK);
      @(negedge MASTERCLK);
      checkValue("COLOROUT", colorModel(cur.x), COLOROUT);
      cx = '0;
      for (int x = 0; x < 160; x++) begin
         cx[0] |= playerModel(x, cur.pos0, cur.nus0, cur.g0, cur.ref0) && pfModel(x);
         cx[1] |= playerModel(x, cur.pos1, 3'd0, cur.g1, 1'b0) && pfModel(x);
         cx[2] |= playerModel(x, cur.pos0, cur.nus0, cur.g0, cur.ref0) &&
                  playerModel(x, cur.pos1, 3'd0, cur.g1, 1'b0);
      end
      @(posedge HBLANK);
      busRead(`TIA_CXP0FB, rd);
      checkValue("CXP0FB", {cx[0], 7'b0}, rd);
      busRead(`TIA_CXP1FB, rd);
      checkValue("CXP1FB", {cx[1], 7'b0}, rd);
      busRead(`TIA_CXPPMM, rd);
      checkValue("CXPPMM", {cx[2], 7'b0}, rd);
   endtask

   initial begin
      int unsigned r;
      int n;
      busDataT rd;
      r = $urandom(32'hfcb6_a3b9);
      collisionLatchReset = 1'b1;
      CS = 1'b0;
      R_W_n = 1'b1;
      A = '0;
      Din = '0;
      // Low bits tag each color so they never coincide
      r = $urandom();
      colP0 = {r[7:3], 3'd1};
      colP1 = {r[15:11], 3'd2};
      colPF = {r[23:19], 3'd3};
      colBK = {r[31:27], 3'd4};

      addRow(8'h10, 8'h00, 8'h00, 8'h00, 3'd0, 1'b0, 8'h00, 8'd10, 8'h00, 8'd100, 8'd2);
      addRow(8'h10, 8'h00, 8'h00, 8'h00, 3'd0, 1'b0, 8'h00, 8'd10, 8'h00, 8'd100, 8'd5);
      addRow(8'h00, 8'h80, 8'h00, 8'h00, 3'd0, 1'b0, 8'h00, 8'd10, 8'h00, 8'd100, 8'd17);
      addRow(8'h00, 8'h00, 8'h01, 8'h00, 3'd0, 1'b0, 8'h00, 8'd10, 8'h00, 8'd100, 8'd49);
      addRow(8'h10, 8'h00, 8'h00, 8'h00, 3'd0, 1'b0, 8'h00, 8'd10, 8'h00, 8'd100, 8'd81);
      addRow(8'h10, 8'h00, 8'h00, 8'h01, 3'd0, 1'b0, 8'h00, 8'd10, 8'h00, 8'd100, 8'd157);
      addRow(8'h10, 8'h00, 8'h80, 8'h02, 3'd0, 1'b0, 8'h00, 8'd10, 8'h00, 8'd100, 8'd2);
      addRow(8'h10, 8'h00, 8'h80, 8'h02, 3'd0, 1'b0, 8'h00, 8'd10, 8'h00, 8'd100, 8'd81);
      addRow(8'h00, 8'h00, 8'h00, 8'h00, 3'd0, 1'b0, 8'hC1, 8'd10, 8'h00, 8'd100, 8'd11);
      addRow(8'h00, 8'h00, 8'h00, 8'h00, 3'd1, 1'b0, 8'hC1, 8'd10, 8'h00, 8'd100, 8'd28);
      addRow(8'h00, 8'h00, 8'h00, 8'h00, 3'd2, 1'b0, 8'hC1, 8'd10, 8'h00, 8'd100, 8'd43);
      addRow(8'h00, 8'h00, 8'h00, 8'h00, 3'd3, 1'b0, 8'hC1, 8'd10, 8'h00, 8'd100, 8'd27);
      addRow(8'h00, 8'h00, 8'h00, 8'h00, 3'd4, 1'b0, 8'hC1, 8'd10, 8'h00, 8'd100, 8'd82);
      addRow(8'h00, 8'h00, 8'h00, 8'h00, 3'd5, 1'b0, 8'hC1, 8'd10, 8'h00, 8'd100, 8'd16);
      addRow(8'h00, 8'h00, 8'h00, 8'h00, 3'd6, 1'b0, 8'hC1, 8'd10, 8'h00, 8'd100, 8'd75);
      addRow(8'h00, 8'h00, 8'h00, 8'h00, 3'd7, 1'b0, 8'hC1, 8'd10, 8'h00, 8'd100, 8'd31);
      addRow(8'h00, 8'h00, 8'h00, 8'h00, 3'd0, 1'b1, 8'hC1, 8'd10, 8'h00, 8'd100, 8'd11);
      addRow(8'h00, 8'h00, 8'h00, 8'h00, 3'd0, 1'b1, 8'hC1, 8'd10, 8'h00, 8'd100, 8'd12);
      addRow(8'hF0, 8'hFF, 8'hFF, 8'h00, 3'd0, 1'b0, 8'hFF, 8'd10, 8'h00, 8'd100, 8'd12);
      addRow(8'hF0, 8'hFF, 8'hFF, 8'h04, 3'd0, 1'b0, 8'hFF, 8'd10, 8'h00, 8'd100, 8'd12);
      addRow(8'h00, 8'h00, 8'h00, 8'h00, 3'd0, 1'b0, 8'hFF, 8'd10, 8'hFF, 8'd10, 8'd12);
      addRow(8'hF0, 8'hFF, 8'hFF, 8'h00, 3'd0, 1'b0, 8'h00, 8'd10, 8'hFF, 8'd40, 8'd45);
      // All three latches set ahead of the collision clear test
      addRow(8'hF0, 8'hFF, 8'hFF, 8'h00, 3'd0, 1'b0, 8'hFF, 8'd80, 8'hFF, 8'd85, 8'd88);

      repeat (2) @(posedge MASTERCLK);
      collisionLatchReset <= 1'b0;
      // Count 0 is the first cycle after release
      @(negedge MASTERCLK);
      checkValue("RDY", 8'd1, {7'b0, RDY});
      checkValue("Dout", 8'h00, Dout);
      n = 0;
      while (HBLANK) begin
         n++;
         @(negedge MASTERCLK);
      end
      checkValue("HBLANK fall count", 8'd68, n[7:0]);
      @(posedge HBLANK);
      for (int c = 0; c < 228; c++) begin
         @(negedge MASTERCLK);
         checkValue("HSYNC", {7'b0, c >= 20 && c < 36}, {7'b0, HSYNC});
         checkValue("HBLANK", {7'b0, c < 68}, {7'b0, HBLANK});
         @(posedge MASTERCLK);
      end
      $display("test 1 reset and line timing finished, errors %0d", errors);

      for (int i = 0; i < rows.size(); i++) begin
         runRow(i);
         $display("test %0d row %0d pixel %0d finished, errors %0d", i + 2, i, cur.x, errors);
      end

      @(posedge HBLANK);
      busWrite(`TIA_CXCLR, 8'h00);
      busRead(`TIA_CXP0FB, rd);
      checkValue("CXP0FB", 8'h00, rd);
      busRead(`TIA_CXP1FB, rd);
      checkValue("CXP1FB", 8'h00, rd);
      busRead(`TIA_CXPPMM, rd);
      checkValue("CXPPMM", 8'h00, rd);
      $display("test %0d collision clear finished, errors %0d", NUM_ROWS + 2, errors);

      // WSYNC driven at count 10, strobe at 11, stall from 12 to the wrap
      @(posedge HBLANK);
      repeat (10) @(posedge MASTERCLK);
      for (int c = 10; c <= 228; c++) begin
         if (c == 10) begin
            CS <= 1'b1;
            R_W_n <= 1'b0;
            A <= `TIA_WSYNC;
         end else if (c == 11) begin
            CS <= 1'b0;
            R_W_n <= 1'b1;
         end
         @(negedge MASTERCLK);
         checkValue("RDY", {7'b0, !(c >= 12 && c <= 227)}, {7'b0, RDY});
         @(posedge MASTERCLK);
      end
      $display("test %0d WSYNC stall finished, errors %0d", NUM_ROWS + 3, errors);

      $display("tests %0d, checks %0d, errors %0d", NUM_ROWS + 3, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: sources.f
+incdir+source
source/tiaPkg.sv
source/tiaBusDecode.sv
source/tiaBeamCounter.sv
source/tiaObjectRegisters.sv
source/tiaPlayerPixel.sv
source/tiaPixelPriority.sv
source/tiaCollisionRead.sv
source/tiaTop.sv
test/tiaTop_properties.sv
test/tiaTop_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the video core testbench with Verilator

verilator --binary --timing --assert -Wno-fatal \
   --top-module tiaTop_tb -f sources.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/VtiaTop_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "TESTBENCH PASSED"; then
   exit 0
fi
exit 1
